/* compile.f */
+incdir+logic
logic/noc_pkg.sv
logic/route_decode.sv
logic/packet_execute.sv
logic/channel_demux.sv
logic/router_port_top.sv
dv/tb_clock_gen.sv
dv/router_port_assertions.sv
dv/router_port_tb.sv

/* Makefile */
# Verilator build and run for the NoC router input port testbench.

VERILATOR  ?= verilator
TOP        := router_port_tb
FILELIST   := compile.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --assert --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --assert --timing --top-module $(TOP)
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# The run fails unless the simulation output holds the pass line.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dv/router_port_tests.txt */
# name target_x target_y body_flits orphan stall_pct
# orphan=1 sends the body flits with no header open, the target is then unused.
local_hop 1 2 3 0 0
north_hop 1 3 3 0 0
east_hop 3 2 2 0 0
south_hop 1 0 4 0 0
west_hop 0 2 2 0 0
east_diag 2 0 5 0 20
west_diag 0 3 5 0 20
single_east 3 1 0 0 0
single_west 0 0 0 0 0
orphan_pair 0 0 2 1 0
stall_north 1 3 12 0 30
orphan_single 0 0 1 1 25
stall_local 1 2 10 0 40
after_orphan_south 1 1 6 0 25
single_north 1 3 0 0 30
stall_west_long 0 1 16 0 35
orphan_burst 2 2 4 1 10

/* dv/router_port_tb.sv */
// Testbench for the router input port; runs the tests file and checks routing and drops.
`timescale 1ns/1ps
`default_nettype none

`include "noc_defines.svh"

module router_port_tb
    import noc_pkg::*;
();

    localparam int ROUTER_X = 1;
    localparam int ROUTER_Y = 2;

    typedef struct packed {
        coord_t     target;
        logic [7:0] body;
        logic       orphan;
        logic [7:0] stall;
    } test_t;

    logic                     clk;
    logic                     rst_n;
    flit_t                    in_flit;
    logic                     in_valid;
    logic                     in_ready;
    flit_t                    out_flit;
    logic [`NOC_CHANNELS-1:0] out_valid;
    logic [`NOC_CHANNELS-1:0] out_ready;
    logic [15:0]              drop_count;

    test_t    tests[$];
    string    test_names[$];
    flit_t    exp_flit_q[$];
    channel_t exp_chan_q[$];
    string    current_test = "reset_state";
    int       error_count = 0;
    int       tests_run = 0;
    int       tests_passed = 0;
    int       cycle_count = 0;
    int       timeout_limit = 0;
    logic [15:0] expected_drops = '0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) u_clock_gen (.clk(clk), .rst_n(rst_n));

    router_port_top #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_flit    (in_flit),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_flit   (out_flit),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .drop_count (drop_count)
    );

    // ------------------------------
    // Reference model and checks
    // ------------------------------
    function automatic channel_t expected_route(input coord_t t);
        if (int'(t.x) > ROUTER_X) return CH_EAST;
        if (int'(t.x) < ROUTER_X) return CH_WEST;
        if (int'(t.y) > ROUTER_Y) return CH_NORTH;
        if (int'(t.y) < ROUTER_Y) return CH_SOUTH;
        return CH_LOCAL;
    endfunction

    task automatic compare_flit(input string name, input flit_t exp, input flit_t act);
        if (act !== exp) begin
            $display("MISMATCH %s flit: expected %h actual %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_channel(input string name, input channel_t exp, input channel_t act);
        if (act !== exp) begin
            $display("MISMATCH %s channel: expected %s actual %s", name, exp.name(), act.name());
            error_count++;
        end
    endtask

    task automatic compare_count(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s drop_count: expected %0d actual %0d", name, exp, act);
            error_count++;
        end
    endtask

    // Every output transfer must match the oldest flit still owed.
    always @(posedge clk) begin : out_monitor
        int ch;
        ch = 0;
        if (rst_n && out_valid != '0) begin
            if ($countones(out_valid) != 1) begin
                $display("Test %s: more than one out_valid bit is high", current_test);
                error_count++;
            end else if (exp_flit_q.size() == 0) begin
                $display("Test %s: out_valid raised with no flit expected", current_test);
                error_count++;
            end else begin
                for (int i = 0; i < `NOC_CHANNELS; i++) begin
                    if (out_valid[i]) begin
                        ch = i;
                    end
                end
                if (out_ready[ch]) begin
                    compare_channel(current_test, exp_chan_q.pop_front(), channel_t'(ch));
                    compare_flit(current_test, exp_flit_q.pop_front(), out_flit);
                end
            end
        end
    end

    // ------------------------------
    // Watchdog
    // ------------------------------
    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Test failures found");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic load_tests(output int total_flits);
        int fd;
        int tx, ty, nb, orph, stall;
        string line, name;
        test_t t;
        total_flits = 0;
        fd = $fopen("dv/router_port_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file dv/router_port_tests.txt");
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;
                if ($sscanf(line, "%s %d %d %d %d %d",
                            name, tx, ty, nb, orph, stall) != 6) continue;
                t.target.x = `NOC_COORD_WIDTH'(tx);
                t.target.y = `NOC_COORD_WIDTH'(ty);
                t.body     = 8'(nb);
                t.orphan   = (orph != 0);
                t.stall    = 8'(stall);
                tests.push_back(t);
                test_names.push_back(name);
                total_flits += (orph != 0) ? nb : nb + 1;
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_ready(input int stall_pct);
        for (int i = 0; i < `NOC_CHANNELS; i++) begin
            out_ready[i] = ($urandom_range(99, 0) >= stall_pct);
        end
    endtask

    // Holds the flit from a falling edge until the rising edge that takes it.
    task automatic send_flit(input flit_t f, input int stall_pct, output int waits);
        waits = 0;
        @(negedge clk);
        in_flit  = f;
        in_valid = 1'b1;
        drive_ready(stall_pct);
        @(posedge clk);
        while (!in_ready) begin
            waits++;
            @(negedge clk);
            drive_ready(stall_pct);
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s (%0d errors)", name, error_count - errors_before);
        end
    endtask

    task automatic run_test(input string name, input test_t t);
        flit_t    f;
        channel_t ch;
        int       waits;
        int       errors_before;
        errors_before = error_count;
        current_test  = name;
        ch = expected_route(t.target);
        if (t.orphan) begin
            for (int k = 0; k < int'(t.body); k++) begin
                f.data = $urandom;
                f.id   = `NOC_ID_WIDTH'($urandom_range(`NOC_HEADER_ID - 1, 0));
                f.last = 1'($urandom_range(1, 0));
                expected_drops = expected_drops + 16'd1;
                send_flit(f, int'(t.stall), waits);
                if (waits != 0) begin
                    $display("Test %s: orphan flit was not accepted in its first cycle", name);
                    error_count++;
                end
            end
        end else begin
            f.data      = $urandom;
            f.data[3:0] = {t.target.y, t.target.x};
            f.id        = `NOC_ID_WIDTH'(`NOC_HEADER_ID);
            f.last      = (t.body == 8'd0);
            exp_flit_q.push_back(f);
            exp_chan_q.push_back(ch);
            send_flit(f, int'(t.stall), waits);
            for (int k = 0; k < int'(t.body); k++) begin
                f.data = $urandom;   // Low bits may look like another target.
                f.id   = `NOC_ID_WIDTH'($urandom_range(`NOC_HEADER_ID - 1, 0));
                f.last = (k == int'(t.body) - 1);
                exp_flit_q.push_back(f);
                exp_chan_q.push_back(ch);
                send_flit(f, int'(t.stall), waits);
            end
        end
        @(negedge clk);
        in_valid  = 1'b0;
        out_ready = '1;
        compare_count(name, expected_drops, drop_count);
        if (exp_flit_q.size() != 0) begin
            $display("Test %s: %0d flits were never delivered", name, exp_flit_q.size());
            error_count++;
            exp_flit_q.delete();
            exp_chan_q.delete();
        end
        report_test(name, errors_before);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int total_flits;
        int total_errors;
        in_flit   = '0;
        in_valid  = 1'b0;
        out_ready = '1;
        void'($urandom(80));
        load_tests(total_flits);
        timeout_limit = 4 * total_flits + 50;

        @(posedge rst_n);
        if (out_valid !== '0) begin
            $display("Test reset_state: out_valid is not low after reset");
            error_count++;
        end
        compare_count("reset_state", 16'd0, drop_count);
        report_test("reset_state", 0);

        foreach (tests[i]) run_test(test_names[i], tests[i]);

        total_errors = error_count + int'(UUT.u_assertions.assert_failures);
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_passed, tests_run - tests_passed, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/router_port_assertions.sv */
// Handshake assertions for the router port outputs, attached to the top level by bind.
`timescale 1ns/1ps
`default_nettype none

`include "noc_defines.svh"

module router_port_assertions
    import noc_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  flit_t                     out_flit,
    input  logic [`NOC_CHANNELS-1:0]  out_valid,
    input  logic [`NOC_CHANNELS-1:0]  out_ready
);

    int unsigned assert_failures = 0;   // Read by the testbench at the end of the run.

    // ------------------------------
    // Output valid encoding
    // ------------------------------
    a_valid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(out_valid))
    else begin
        $error("out_valid has more than one bit set");
        assert_failures++;
    end

    // A stalled output must not move to another channel or change its flit.
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ((out_valid != '0) && ((out_valid & out_ready) == '0))
        |=> ((out_valid == $past(out_valid)) && $stable(out_flit)))
    else begin
        $error("stalled output flit or valid changed before transfer");
        assert_failures++;
    end

    // ------------------------------
    // Reset
    // ------------------------------
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (out_valid == '0))
    else begin
        $error("out_valid high while reset is asserted");
        assert_failures++;
    end

endmodule

bind router_port_top router_port_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

`default_nettype wire

/* dv/tb_clock_gen.sv */
// Testbench clock and reset; a free running clock and an active low reset held a few cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release happens on a falling edge, away from the DUT's sampling edge.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* logic/router_port_top.sv */
// Top level of one mesh router input port; connects route decode, packet execute and demux.
`timescale 1ns/1ps
`default_nettype none

`include "noc_defines.svh"

module router_port_top
    import noc_pkg::*;
#(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,

    input  flit_t                     in_flit,
    input  logic                      in_valid,
    output logic                      in_ready,

    output flit_t                     out_flit,
    output logic [`NOC_CHANNELS-1:0]  out_valid,
    input  logic [`NOC_CHANNELS-1:0]  out_ready,

    output logic [15:0]               drop_count
);

    channel_t route;

    flit_t    sel_flit;
    logic     sel_valid;
    logic     sel_ready;
    channel_t sel_channel;

    // ------------------------------
    // Route decode
    // ------------------------------
    route_decode #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) u_route_decode (
        .in_flit (in_flit),
        .route   (route)
    );

    // ------------------------------
    // Packet execute
    // ------------------------------
    packet_execute u_packet_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_flit     (in_flit),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .route       (route),
        .sel_flit    (sel_flit),
        .sel_valid   (sel_valid),
        .sel_ready   (sel_ready),
        .sel_channel (sel_channel),
        .drop_count  (drop_count)
    );

    // ------------------------------
    // Channel demux
    // ------------------------------
    channel_demux u_channel_demux (
        .sel_flit    (sel_flit),
        .sel_valid   (sel_valid),
        .sel_channel (sel_channel),
        .sel_ready   (sel_ready),
        .out_flit    (out_flit),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

/* logic/channel_demux.sv */
// Output demultiplexer of the router port; raises one valid bit and returns that channel's ready.
`timescale 1ns/1ps
`default_nettype none

`include "noc_defines.svh"

module channel_demux
    import noc_pkg::*;
(
    input  flit_t                     sel_flit,
    input  logic                      sel_valid,
    input  channel_t                  sel_channel,
    output logic                      sel_ready,

    output flit_t                     out_flit,
    output logic [`NOC_CHANNELS-1:0]  out_valid,
    input  logic [`NOC_CHANNELS-1:0]  out_ready
);

    // ------------------------------
    // Shared flit bus
    // ------------------------------
    // Only the channel with its valid bit high samples the bus.
    assign out_flit = sel_flit;

    // ------------------------------
    // Valid steering and ready return
    // ------------------------------
    // A channel code outside the table matches no output, so it stalls.
    always_comb begin
        out_valid = '0;
        sel_ready = 1'b0;
        for (int i = 0; i < `NOC_CHANNELS; i++) begin
            if (int'(sel_channel) == i) begin
                out_valid[i] = sel_valid;
                sel_ready    = out_ready[i];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/packet_execute.sv */
// Packet lock for the input port; selects the channel of every flit and drops orphan body flits.
`timescale 1ns/1ps
`default_nettype none

`include "noc_defines.svh"

module packet_execute
    import noc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  flit_t       in_flit,
    input  logic        in_valid,
    output logic        in_ready,

    input  channel_t    route,

    output flit_t       sel_flit,
    output logic        sel_valid,
    input  logic        sel_ready,
    output channel_t    sel_channel,

    output logic [15:0] drop_count
);

    logic     lock_active;
    channel_t lock_channel;

    logic is_header;
    logic orphan;
    logic transfer;

    // ------------------------------
    // Flit classification
    // ------------------------------
    assign is_header = (in_flit.id == `NOC_ID_WIDTH'(`NOC_HEADER_ID));

    // A body flit with no open packet has nowhere to go.
    assign orphan = in_valid && !is_header && !lock_active;

    // ------------------------------
    // Channel selection and handshake
    // ------------------------------
    assign sel_flit    = in_flit;
    assign sel_valid   = in_valid && !orphan;
    assign sel_channel = is_header ? route : lock_channel;

    // Orphans are swallowed at once, everything else waits for the output.
    assign in_ready = orphan ? 1'b1 : sel_ready;

    assign transfer = in_valid && in_ready;

    // ------------------------------
    // Packet lock
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_active  <= 1'b0;
            lock_channel <= CH_LOCAL;
        end else if (transfer && !orphan) begin
            if (is_header) begin
                lock_active  <= !in_flit.last;   // A one-flit packet never locks.
                lock_channel <= route;
            end else if (in_flit.last) begin
                lock_active <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Drop counter
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (transfer && orphan) begin
            drop_count <= drop_count + 16'd1;
        end
    end

endmodule

`default_nettype wire

/* logic/route_decode.sv */
// XY route computation; maps the target coordinates of a header flit to an output channel.
`timescale 1ns/1ps
`default_nettype none

`include "noc_defines.svh"

module route_decode
    import noc_pkg::*;
#(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  flit_t    in_flit,
    output channel_t route
);

    // ------------------------------
    // Coordinates
    // ------------------------------
    localparam coord_t own = '{
        x: ROUTER_X[`NOC_COORD_WIDTH-1:0],
        y: ROUTER_Y[`NOC_COORD_WIDTH-1:0]
    };

    coord_t target;

    // The target sits in the low bits of the header payload, x below y.
    assign target.x = in_flit.data[`NOC_COORD_WIDTH-1:0];
    assign target.y = in_flit.data[2*`NOC_COORD_WIDTH-1:`NOC_COORD_WIDTH];

    // ------------------------------
    // Dimension-ordered routing
    // ------------------------------
    // X is resolved first, so a packet only turns once on its way.
    always_comb begin
        if (target.x > own.x) begin
            route = CH_EAST;
        end else if (target.x < own.x) begin
            route = CH_WEST;
        end else if (target.y > own.y) begin
            route = CH_NORTH;   // Y grows towards north.
        end else if (target.y < own.y) begin
            route = CH_SOUTH;
        end else begin
            route = CH_LOCAL;   // Packet has arrived.
        end
    end

endmodule

`default_nettype wire

/* logic/noc_pkg.sv */
// Flit, channel and coordinate types shared by the router port RTL and its testbench.
`default_nettype none

`include "noc_defines.svh"

package noc_pkg;

    // ------------------------------
    // Flit on the input and output streams
    // ------------------------------
    // In a header flit, data[1:0] is the target x and data[3:2] the target y.
    typedef struct packed {
        logic [`NOC_DATA_WIDTH-1:0] data;
        logic [`NOC_ID_WIDTH-1:0]   id;
        logic                       last;
    } flit_t;

    // ------------------------------
    // Output channels of the port
    // ------------------------------
    typedef enum logic [2:0] {
        CH_LOCAL = 3'd0,
        CH_NORTH = 3'd1,
        CH_EAST  = 3'd2,
        CH_SOUTH = 3'd3,
        CH_WEST  = 3'd4
    } channel_t;

    // Position of a router in the mesh.
    typedef struct packed {
        logic [`NOC_COORD_WIDTH-1:0] x;
        logic [`NOC_COORD_WIDTH-1:0] y;
    } coord_t;

endpackage

`default_nettype wire

/* logic/noc_defines.svh */
// Widths, mesh size and header ID for the NoC input port, included by the package and RTL.
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// ------------------------------
// Flit fields
// ------------------------------
`define NOC_DATA_WIDTH 32
`define NOC_ID_WIDTH 4

// Reserved ID that marks the first flit of a packet.
`define NOC_HEADER_ID 15

// ------------------------------
// Mesh geometry
// ------------------------------
`define NOC_CHANNELS 5
`define NOC_MESH_X 4
`define NOC_MESH_Y 4

// Enough bits to address any row or column of the mesh.
`define NOC_COORD_WIDTH 2

`endif
